// File: accessPkg.sv
package accessPkg;

  //////////////////////////////////////////////////////////////////////
  // Access encodings
  //////////////////////////////////////////////////////////////////////

  // Kind of access presented by the requester
  // An atomic access needs both read and write permission
  typedef enum logic [1:0] {
    kindRead    = 2'd0,
    kindWrite   = 2'd1,
    kindExecute = 2'd2,
    kindAtomic  = 2'd3
  } accessKindT;

  // Access size, the value is log2 of the number of bytes
  // It also indexes the per-region size masks in the memory map
  typedef enum logic [1:0] {
    sizeByte   = 2'd0,
    sizeHalf   = 2'd1,
    sizeWord   = 2'd2,
    sizeDouble = 2'd3
  } accessSizeT;

  //////////////////////////////////////////////////////////////////////
  // Checked result of one access
  //////////////////////////////////////////////////////////////////////

  // Attributes of the region hit come first, then the squash and the faults
  // At most one of the three fault bits is set for a given access
  typedef struct packed {
    logic cacheable;
    logic idempotent;
    logic atomicAllowed;
    logic squashBusAccess;
    logic instrAccessFault;
    logic loadAccessFault;
    logic storeAccessFault;
  } pmaResultT;

endpackage

// File: adrDec.sv
`timescale 1ns/1ps

module adrDec #(
  parameter int                 PA_BITS = 34,
  parameter logic [PA_BITS-1:0] BASE    = '0,
  parameter logic [PA_BITS-1:0] RANGE   = '0,
  parameter logic [2:0]         PERM    = 3'b000,
  parameter logic [3:0]         SIZES   = 4'b0000
) (
  input  logic [PA_BITS-1:0]    physicalAddress,
  input  accessPkg::accessSizeT size,
  input  logic                  accessRW,
  input  logic                  accessRX,
  input  logic                  accessRWX,
  output logic                  sel
);
  import memMapPkg::*;

  logic addrMatch;
  logic permMatch;
  logic sizeMatch;

  // Bits under the range are free offset bits inside the region
  // Only the bits above it have to equal the base
  assign addrMatch = (physicalAddress & ~RANGE) == (BASE & ~RANGE);

  // The region's permission picks the access input it is allowed to accept
  // Each input is only high when the access needs nothing beyond that set
  // Anything that is not RX or RWX is treated as a read/write region
  assign permMatch = (PERM == permRWX) ? accessRWX :
                     (PERM == permRX)  ? accessRX  :
                                         accessRW;

  // The size encoding indexes straight into the mask of allowed sizes
  assign sizeMatch = SIZES[size];

  // Region is selected only when all three checks agree
  assign sel = addrMatch & permMatch & sizeMatch;

endmodule

// File: adrDecs.sv
`timescale 1ns/1ps

module adrDecs #(
  parameter int PA_BITS = 34
) (
  input  logic [PA_BITS-1:0]    physicalAddress,
  input  accessPkg::accessSizeT size,
  input  logic                  accessRW,
  input  logic                  accessRX,
  input  logic                  accessRWX,
  output memMapPkg::regionSelT  sel
);
  import memMapPkg::*;

  // One hit bit per real region, driven by its own decoder
  logic [regionCount-1:0] hit;

  //////////////////////////////////////////////////////////////////////
  // Per-region decoders
  //////////////////////////////////////////////////////////////////////

  // Map constants are sized to PA_BITS here, so a narrower address
  // drops the unused top bits and a wider one zero extends them
  for (genvar i = 0; i < regionCount; i++) begin : gRegion
    adrDec #(
      .PA_BITS (PA_BITS),
      .BASE    (PA_BITS'(regionBase[i])),
      .RANGE   (PA_BITS'(regionRange[i])),
      .PERM    (regionPerm[i]),
      .SIZES   (regionSizes[i])
    ) dec (
      .physicalAddress (physicalAddress),
      .size            (size),
      .accessRW        (accessRW),
      .accessRX        (accessRX),
      .accessRWX       (accessRWX),
      .sel             (hit[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Select vector
  //////////////////////////////////////////////////////////////////////

  // Regions do not overlap, so at most one hit bit is set
  // noRegion sits on top and is set when none of the decoders accepted
  // This also covers an address inside a region with a bad size or kind
  assign sel = {~|hit, hit};

endmodule

// File: memMapPkg.sv
package memMapPkg;

  //////////////////////////////////////////////////////////////////////
  // Region indices and select vector
  //////////////////////////////////////////////////////////////////////

  // Number of real regions, the select vector carries one bit more
  localparam int regionCount = 6;

  // Region indices, these are also the bit positions in a select vector
  localparam int regionUart    = 0;
  localparam int regionGpio    = 1;
  localparam int regionPlic    = 2;
  localparam int regionClint   = 3;
  localparam int regionMainRam = 4;
  localparam int regionBootRom = 5;

  // Top bit flags an access that no region accepted
  localparam int regionNone = regionCount;

  typedef logic [regionCount:0] regionSelT;

  // Map constants span the full 34 bit default physical space
  typedef logic [33:0] addrConstT;

  //////////////////////////////////////////////////////////////////////
  // Permission and size masks
  //////////////////////////////////////////////////////////////////////

  // Permission bits: 2 is read, 1 is write, 0 is execute
  localparam logic [2:0] permRW  = 3'b110;
  localparam logic [2:0] permRX  = 3'b101;
  localparam logic [2:0] permRWX = 3'b111;

  // One bit per access size value, bit 0 byte up to bit 3 double
  localparam logic [3:0] sizesByte       = 4'b0001;
  localparam logic [3:0] sizesWord       = 4'b0100;
  localparam logic [3:0] sizesWordDouble = 4'b1100;
  localparam logic [3:0] sizesAll        = 4'b1111;

  //////////////////////////////////////////////////////////////////////
  // Fixed memory map
  //////////////////////////////////////////////////////////////////////

  // Every base is aligned to its range, so the range acts as a low mask
  localparam addrConstT regionBase [regionCount] = '{
    regionUart:    34'h0_1000_0000,
    regionGpio:    34'h0_1006_0000,
    regionPlic:    34'h0_0C00_0000,
    regionClint:   34'h0_0200_0000,
    regionMainRam: 34'h0_8000_0000,
    regionBootRom: 34'h0_0000_1000
  };

  localparam addrConstT regionRange [regionCount] = '{
    regionUart:    34'h0_0000_0007,
    regionGpio:    34'h0_0000_00FF,
    regionPlic:    34'h0_03FF_FFFF,
    regionClint:   34'h0_0000_FFFF,
    regionMainRam: 34'h0_0FFF_FFFF,
    regionBootRom: 34'h0_0000_0FFF
  };

  // Only main memory holds code that may also be written
  localparam logic [2:0] regionPerm [regionCount] = '{
    regionUart:    permRW,
    regionGpio:    permRW,
    regionPlic:    permRW,
    regionClint:   permRW,
    regionMainRam: permRWX,
    regionBootRom: permRX
  };

  // Peripheral registers only take their native width
  localparam logic [3:0] regionSizes [regionCount] = '{
    regionUart:    sizesByte,
    regionGpio:    sizesWord,
    regionPlic:    sizesWord,
    regionClint:   sizesWordDouble,
    regionMainRam: sizesAll,
    regionBootRom: sizesAll
  };

endpackage

// File: pmaChecker.sv
`timescale 1ns/1ps

module pmaChecker (
  pmaIf.check bus
);
  import accessPkg::*;
  import memMapPkg::*;

  logic       readAccess;
  logic       writeAccess;
  logic       executeAccess;
  logic       accessRW;
  logic       accessRX;
  logic       accessRWX;
  logic       accessFault;
  regionSelT  sel;

  //////////////////////////////////////////////////////////////////////
  // Access intent
  //////////////////////////////////////////////////////////////////////

  // An atomic access reads and writes the same location
  assign readAccess    = (bus.accessKind == kindRead) | (bus.accessKind == kindAtomic);
  assign writeAccess   = (bus.accessKind == kindWrite) | (bus.accessKind == kindAtomic);
  assign executeAccess = bus.accessKind == kindExecute;

  // Each class is set only when the access fits entirely inside it
  // So a write or an atomic never passes as RX
  assign accessRW  = (readAccess | writeAccess) & ~executeAccess;
  assign accessRX  = (readAccess | executeAccess) & ~writeAccess;
  assign accessRWX = readAccess | writeAccess | executeAccess;

  // Address width comes from the interface this checker is bound to
  adrDecs #(
    .PA_BITS ($bits(bus.physicalAddress))
  ) decs (
    .physicalAddress (bus.physicalAddress),
    .size            (bus.size),
    .accessRW        (accessRW),
    .accessRX        (accessRX),
    .accessRWX       (accessRWX),
    .sel             (sel)
  );

  // A fault needs an actual access that no region accepted
  assign accessFault = sel[regionNone] & accessRWX;

  //////////////////////////////////////////////////////////////////////
  // Attributes and fault routing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Both memories may be cached, only main memory is plain RAM
    bus.result.cacheable     = sel[regionMainRam] | sel[regionBootRom];
    bus.result.idempotent    = sel[regionMainRam];
    bus.result.atomicAllowed = sel[regionMainRam];

    // The bus access is dropped whenever the access faults
    bus.result.squashBusAccess = accessFault;

    // Fault goes to the pipeline stage that issued the access
    // An atomic fault counts as a store fault, never as a load fault
    bus.result.instrAccessFault = accessFault & executeAccess;
    bus.result.loadAccessFault  = accessFault & (bus.accessKind == kindRead);
    bus.result.storeAccessFault = accessFault & writeAccess;
  end

endmodule

// File: pmaIf.sv
`timescale 1ns/1ps

interface pmaIf #(
  parameter int PA_BITS = 34
);
  import accessPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Captured access and its checked result
  //////////////////////////////////////////////////////////////////////

  // Access as registered by the request controller
  logic [PA_BITS-1:0] physicalAddress;
  accessSizeT         size;
  accessKindT         accessKind;

  // Combinational answer of the checker for the access above
  pmaResultT          result;

  // Request side owns the access and samples the result
  modport ctrl (
    output physicalAddress,
    output size,
    output accessKind,
    input  result
  );

  // Checker side looks at the access and answers with the result
  modport check (
    input  physicalAddress,
    input  size,
    input  accessKind,
    output result
  );

endinterface

// File: pmaRequestCtrl.sv
`timescale 1ns/1ps

module pmaRequestCtrl #(
  parameter int PA_BITS = 34
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic [PA_BITS-1:0]    physicalAddress,
  input  accessPkg::accessSizeT size,
  input  accessPkg::accessKindT accessKind,
  output logic                  ack,
  output accessPkg::pmaResultT  result,
  pmaIf.ctrl                    bus
);

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  // idle waits for a new request
  // capture registers the access onto the interface
  // respond registers the checked result and raises ack
  // waitRelease holds ack and result until req drops
  typedef enum logic [1:0] {
    stIdle,
    stCapture,
    stRespond,
    stWaitRelease
  } ctrlStateT;

  ctrlStateT state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= stIdle;
      ack    <= 1'b0;
      result <= '0;
    end else begin
      case (state)
        stIdle: begin
          // ack from the previous access falls on the first idle edge
          ack <= 1'b0;
          // A request only counts once the last ack has been lowered
          if (req && !ack) begin
            state <= stCapture;
          end
        end
        stCapture: begin
          // Access lands on the interface at this edge, checker settles
          state <= stRespond;
        end
        stRespond: begin
          result <= bus.result;
          ack    <= 1'b1;
          state  <= stWaitRelease;
        end
        stWaitRelease: begin
          // Requester may hold req as long as it likes, nothing changes
          if (!req) begin
            state <= stIdle;
          end
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Access capture
  //////////////////////////////////////////////////////////////////////

  // The requester holds its inputs stable while req is high
  // Registering them keeps the checker input quiet for the whole access
  always_ff @(posedge clk) begin
    if (state == stCapture) begin
      bus.physicalAddress <= physicalAddress;
      bus.size            <= size;
      bus.accessKind      <= accessKind;
    end
  end

endmodule

// File: pmaUnit.sv
`timescale 1ns/1ps

module pmaUnit #(
  parameter int PA_BITS = 34
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic [PA_BITS-1:0]    physicalAddress,
  input  accessPkg::accessSizeT size,
  input  accessPkg::accessKindT accessKind,
  output logic                  ack,
  output accessPkg::pmaResultT  result
);

  //////////////////////////////////////////////////////////////////////
  // Request controller and checker
  //////////////////////////////////////////////////////////////////////

  // Carries the captured access to the checker and its answer back
  pmaIf #(
    .PA_BITS (PA_BITS)
  ) bus ();

  // Four-phase handshake with the requester, one access in flight
  pmaRequestCtrl #(
    .PA_BITS (PA_BITS)
  ) reqCtrl (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .physicalAddress (physicalAddress),
    .size            (size),
    .accessKind      (accessKind),
    .ack             (ack),
    .result          (result),
    .bus             (bus.ctrl)
  );

  // Purely combinational, the controller samples it one cycle later
  pmaChecker pmaCheck (
    .bus (bus.check)
  );

endmodule

// File: pmaUnitTb.sv
`timescale 1ns/1ps

module pmaUnitTb;
  import accessPkg::*;

  localparam int directedCount = 21;
  localparam int randomCount   = 300;
  localparam int resetCycles   = 8;
  localparam int ackLimit      = 10;
  // Every access takes at most 7 cycles, the rest is margin
  localparam int runCycles     = (directedCount + randomCount) * 8 + resetCycles;

  //////////////////////////////////////////////////////////////////////
  // Reference memory map, one entry per region
  //////////////////////////////////////////////////////////////////////

  // Order is uart, gpio, plic, clint, mainRam, bootRom
  localparam logic [33:0] mapBase [6] = '{34'h1000_0000, 34'h1006_0000, 34'h0C00_0000,
                                          34'h0200_0000, 34'h8000_0000, 34'h0000_1000};
  localparam logic [33:0] mapRange [6] = '{34'h7, 34'hFF, 34'h03FF_FFFF,
                                           34'hFFFF, 34'h0FFF_FFFF, 34'hFFF};
  // Bit i of each vector belongs to region i
  localparam logic [5:0] mapRead  = 6'b111111;
  localparam logic [5:0] mapWrite = 6'b011111;
  localparam logic [5:0] mapExec  = 6'b110000;
  // Bit 0 is byte up to bit 3 for double
  localparam logic [3:0] mapSizes [6] = '{4'b0001, 4'b0100, 4'b0100,
                                          4'b1100, 4'b1111, 4'b1111};

  logic        clk;
  logic        reset;
  logic        req;
  logic [33:0] physicalAddress;
  accessSizeT  size;
  accessKindT  accessKind;
  logic        ack;
  pmaResultT   result;

  pmaResultT   expResult;
  logic [33:0] expAddr;
  logic [31:0] lcgState;
  logic        ackPrev;
  int          ackCount;
  int          mismatchCount;
  int          protocolCount;

  pmaUnit #(
    .PA_BITS (34)
  ) i_dut (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .physicalAddress (physicalAddress),
    .size            (size),
    .accessKind      (accessKind),
    .ack             (ack),
    .result          (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and expected results
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Pools: inside a region, one byte beyond its edges, anywhere
  function automatic logic [33:0] pickAddress();
    logic [31:0] r0;
    logic [31:0] r1;
    int          region;
    r0 = lcgNext();
    r1 = lcgNext();
    // High LCG bits have the longest period
    region = r0[23:16] % 6;
    case (r0[31:24] % 3)
      0: return mapBase[region] + ({r1[31:30], r1} & mapRange[region]);
      1: return r1[31] ? mapBase[region] + mapRange[region] + 34'd1 : mapBase[region] - 34'd1;
      default: return {r0[1:0], r1};
    endcase
  endfunction

  function automatic pmaResultT pmaExpect(input logic [33:0] addr, input accessSizeT sz,
                                          input accessKindT kind);
    pmaResultT res;
    logic      needRead;
    logic      needWrite;
    logic      needExec;
    int        hitIdx;
    res       = '0;
    needRead  = (kind == kindRead) || (kind == kindAtomic);
    needWrite = (kind == kindWrite) || (kind == kindAtomic);
    needExec  = kind == kindExecute;
    hitIdx    = -1;
    for (int i = 0; i < 6; i++) begin
      if (addr >= mapBase[i] && addr <= mapBase[i] + mapRange[i] &&
          (!needRead || mapRead[i]) && (!needWrite || mapWrite[i]) &&
          (!needExec || mapExec[i]) && mapSizes[i][sz]) begin
        hitIdx = i;
      end
    end
    if (hitIdx < 0) begin
      // Atomic faults land on the store side only
      res.squashBusAccess  = 1'b1;
      res.instrAccessFault = needExec;
      res.storeAccessFault = needWrite;
      res.loadAccessFault  = needRead && !needWrite;
    end else begin
      res.cacheable     = (hitIdx == 4) || (hitIdx == 5);
      res.idempotent    = hitIdx == 4;
      res.atomicAllowed = hitIdx == 4;
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Requester side of the handshake
  //////////////////////////////////////////////////////////////////////

  // faultExp of -1 leaves the fault outcome to the comparing process alone
  task automatic runAccess(input logic [33:0] addr, input accessSizeT sz, input accessKindT kind,
                           input int faultExp, input int holdCycles);
    int waitCount;
    expResult       = pmaExpect(addr, sz, kind);
    expAddr         = addr;
    physicalAddress = addr;
    size            = sz;
    accessKind      = kind;
    req             = 1'b1;
    @(negedge clk);
    waitCount = 1;
    while (!ack && waitCount < ackLimit) begin
      @(negedge clk);
      waitCount++;
    end
    // Third falling edge is two cycles after the edge that saw req
    assert (ack && waitCount == 3) else begin
      protocolCount++;
      $display("Protocol error at %0t: ack did not rise two cycles after req", $time);
    end
    if (faultExp >= 0) begin
      assert (result.squashBusAccess == faultExp[0]) else begin
        mismatchCount++;
        $display("Mismatch at %0t: squash %b for address %h, expected %0d",
                 $time, result.squashBusAccess, addr, faultExp);
      end
    end
    repeat (holdCycles) begin
      @(negedge clk);
      assert (ack) else begin
        protocolCount++;
        $display("Protocol error at %0t: ack dropped while req was still high", $time);
      end
    end
    req = 1'b0;
    @(negedge clk);
    waitCount = 1;
    while (ack && waitCount < ackLimit) begin
      @(negedge clk);
      waitCount++;
    end
    assert (!ack && waitCount == 2) else begin
      protocolCount++;
      $display("Protocol error at %0t: ack did not fall one cycle after req dropped", $time);
    end
  endtask

  // Checks every cycle of a high ack, which also covers a held result
  always @(negedge clk) begin
    if (!reset) begin
      if (ack) begin
        assert (result == expResult) else begin
          mismatchCount++;
          $display("Mismatch at %0t: result %b for address %h, expected %b",
                   $time, result, expAddr, expResult);
        end
      end
      if (ack && !ackPrev) ackCount++;
      ackPrev = ack;
    end
  end

  initial begin
    #(runCycles * 4 + 64);
    $display("Watchdog timeout at %0t: the run did not finish in time", $time);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [33:0] addr;
    reset           = 1'b1;
    req             = 1'b0;
    physicalAddress = '0;
    size            = sizeByte;
    accessKind      = kindRead;
    expResult       = '0;
    expAddr         = '0;
    lcgState        = 32'h1f6e_4369;
    ackPrev         = 1'b0;
    ackCount        = 0;
    mismatchCount   = 0;
    protocolCount   = 0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (!ack && result == '0) else begin
      mismatchCount++;
      $display("Mismatch at %0t: ack %b result %b after reset", $time, ack, result);
    end

    // Main memory takes every kind and gets all attributes
    runAccess(34'h8000_0040, sizeWord, kindRead, 0, 1);
    runAccess(34'h8123_4568, sizeDouble, kindWrite, 0, 0);
    runAccess(34'h8FFF_FFFC, sizeWord, kindExecute, 0, 2);
    runAccess(34'h8000_1000, sizeWord, kindAtomic, 0, 0);
    runAccess(34'h0000_1800, sizeWord, kindRead, 0, 1);
    // Permission and size violations inside a region
    runAccess(34'h0000_1004, sizeWord, kindWrite, 1, 0);
    runAccess(34'h1000_0003, sizeByte, kindExecute, 1, 2);
    runAccess(34'h1006_0010, sizeByte, kindRead, 1, 0);
    // Atomic outside main memory goes to the store fault
    runAccess(34'h0000_1008, sizeWord, kindAtomic, 1, 1);
    for (int i = 0; i < 6; i++) begin
      runAccess(mapBase[i] - 34'd1, (i == 0) ? sizeByte : sizeWord, kindRead, 1, 0);
      runAccess(mapBase[i] + mapRange[i] + 34'd1, (i == 0) ? sizeByte : sizeWord,
                kindRead, 1, 1);
    end

    repeat (randomCount) begin
      addr = pickAddress();
      r    = lcgNext();
      runAccess(addr, accessSizeT'(r[29:28]), accessKindT'(r[27:26]), -1, r[31:24] % 3);
    end

    @(negedge clk);
    assert (ackCount == directedCount + randomCount) else begin
      protocolCount++;
      $display("Protocol error: saw %0d acks for %0d accesses",
               ackCount, directedCount + randomCount);
    end
    $display("Errors: %0d mismatches, %0d protocol errors", mismatchCount, protocolCount);
    if (mismatchCount == 0 && protocolCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: vlog.f
accessPkg.sv
memMapPkg.sv
pmaIf.sv
adrDec.sv
adrDecs.sv
pmaChecker.sv
pmaRequestCtrl.sv
pmaUnit.sv
pmaUnitTb.sv
